/* design/gpu_ctrl_defs.svh */
`ifndef GPU_CTRL_DEFS_SVH
`define GPU_CTRL_DEFS_SVH

// depth of gpu memory in 32-bit words
`define GPU_MEM_WORDS 256

// clock cycles in one unit of the launch timeout
`define GPU_TIMEOUT_UNIT 1000

// parameter words following every instruction except nop
// copies send address then byte count
// launches send kernel address then timeout
`define GPU_NUM_PARAMS 2

`endif

/* design/gpu_ctrl_pkg.sv */
`default_nettype none

`include "gpu_ctrl_defs.svh"

package gpu_ctrl_pkg;

    // one instruction, parameter or data word
    typedef logic [31:0] gpu_word_t;

    // byte address or byte count as seen by the host
    typedef logic [31:0] gpu_addr_t;

    // word index into gpu memory
    typedef logic [$clog2(`GPU_MEM_WORDS)-1:0] mem_index_t;

    // host opcodes, a full word wide
    typedef enum logic [31:0] {
        NOP           = 32'd0,
        COPY_TO_GPU   = 32'd1,
        COPY_FROM_GPU = 32'd2,
        KERNEL_LAUNCH = 32'd3
    } host_instr_e;

    // host controller states
    typedef enum logic [2:0] {
        IDLE,
        RECV_PARAMS,
        RECEIVE_DATA,
        READ_MEM,
        SEND_DATA,
        LAUNCH
    } host_state_e;

endpackage

`default_nettype wire

/* design/gpu_memory.sv */
`default_nettype none

`include "gpu_ctrl_defs.svh"

module gpu_memory (
    input  logic                     clk,
    // write port
    input  logic                     we,
    input  gpu_ctrl_pkg::mem_index_t waddr,
    input  gpu_ctrl_pkg::gpu_word_t  wdata,
    // read port
    input  logic                     re,
    input  gpu_ctrl_pkg::mem_index_t raddr,
    output gpu_ctrl_pkg::gpu_word_t  rdata
);
    import gpu_ctrl_pkg::*;

    // word storage
    gpu_word_t mem [`GPU_MEM_WORDS];

    // write lands on its edge
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // registered read, one cycle latency
    // rdata holds between reads
    // same-address read and write returns the old word
    always_ff @(posedge clk) begin
        if (re) begin
            rdata <= mem[raddr];
        end
    end

endmodule

`default_nettype wire

/* design/host_controller.sv */
`default_nettype none

`include "gpu_ctrl_defs.svh"

module host_controller (
    input  logic                     clk,
    input  logic                     rst,
    // instruction channel
    input  logic                     instr_valid,
    input  gpu_ctrl_pkg::host_instr_e instr,
    output logic                     instr_ready,
    output logic                     instr_error,
    // parameter and copy-in channel
    input  logic                     in_valid,
    input  gpu_ctrl_pkg::gpu_word_t  in_data,
    output logic                     in_ready,
    // copy-out channel
    output logic                     out_valid,
    output gpu_ctrl_pkg::gpu_word_t  out_data,
    input  logic                     out_ready,
    // memory write port
    output logic                     mem_we,
    output gpu_ctrl_pkg::mem_index_t mem_waddr,
    output gpu_ctrl_pkg::gpu_word_t  mem_wdata,
    // memory read port
    output logic                     mem_re,
    output gpu_ctrl_pkg::mem_index_t mem_raddr,
    input  gpu_ctrl_pkg::gpu_word_t  mem_rdata,
    // launch handshake
    output logic                     launch_valid,
    output gpu_ctrl_pkg::gpu_addr_t  launch_pc,
    output gpu_ctrl_pkg::gpu_word_t  launch_timeout,
    input  logic                     launch_ready
);
    import gpu_ctrl_pkg::*;

    localparam int PARAM_POS_W = $clog2(`GPU_NUM_PARAMS);
    localparam logic [PARAM_POS_W-1:0] LAST_PARAM = PARAM_POS_W'(`GPU_NUM_PARAMS - 1);

    host_state_e state;
    host_state_e state_next;

    // opcode latched when the instruction is taken
    host_instr_e opcode;

    // parameter words in arrival order
    gpu_word_t params [`GPU_NUM_PARAMS];
    logic [PARAM_POS_W-1:0] param_pos;

    // current byte address and exclusive end of the copy
    // compare against the end instead of counting down
    gpu_addr_t data_addr;
    gpu_addr_t end_addr;
    gpu_addr_t addr_next;

    logic instr_xfer;
    logic instr_known;
    logic in_xfer;
    logic out_xfer;
    logic last_param;

    // byte address to word index, low two bits dropped
    // upper bits wrap modulo memory depth
    function automatic mem_index_t to_index(input gpu_addr_t byte_addr);
        return byte_addr[$bits(mem_index_t)+1:2];
    endfunction

    assign instr_xfer = instr_valid && instr_ready;
    assign in_xfer    = in_valid && in_ready;
    assign out_xfer   = out_valid && out_ready;
    assign last_param = (param_pos == LAST_PARAM);
    assign addr_next  = data_addr + 32'd4;

    // opcodes that take parameters
    always_comb begin
        case (instr)
            COPY_TO_GPU, COPY_FROM_GPU, KERNEL_LAUNCH: instr_known = 1'b1;
            default: instr_known = 1'b0;
        endcase
    end

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                // nop and unknown opcodes stay here
                if (instr_xfer && instr_known) begin
                    state_next = RECV_PARAMS;
                end
            end
            RECV_PARAMS: begin
                if (in_xfer && last_param) begin
                    // final word is the count or the timeout
                    case (opcode)
                        COPY_TO_GPU: begin
                            state_next = (in_data == '0) ? IDLE : RECEIVE_DATA;
                        end
                        COPY_FROM_GPU: begin
                            state_next = (in_data == '0) ? IDLE : READ_MEM;
                        end
                        KERNEL_LAUNCH: begin
                            state_next = LAUNCH;
                        end
                        default: begin
                            state_next = IDLE;
                        end
                    endcase
                end
            end
            RECEIVE_DATA: begin
                if (in_xfer && (addr_next == end_addr)) begin
                    state_next = IDLE;
                end
            end
            READ_MEM: begin
                // read data is back in the next cycle
                state_next = SEND_DATA;
            end
            SEND_DATA: begin
                if (out_xfer) begin
                    state_next = (addr_next == end_addr) ? IDLE : READ_MEM;
                end
            end
            LAUNCH: begin
                // launcher holds us off while a kernel runs
                if (launch_ready) begin
                    state_next = IDLE;
                end
            end
            default: begin
                state_next = IDLE;
            end
        endcase
    end

    // control state
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state       <= IDLE;
            param_pos   <= '0;
            instr_ready <= 1'b0;
            in_ready    <= 1'b0;
            out_valid   <= 1'b0;
            instr_error <= 1'b0;
        end else begin
            state <= state_next;
            // handshake flags follow the next state
            instr_ready <= (state_next == IDLE);
            in_ready    <= (state_next == RECV_PARAMS) || (state_next == RECEIVE_DATA);
            out_valid   <= (state_next == SEND_DATA);
            // one-cycle pulse for a dropped opcode
            instr_error <= instr_xfer && !instr_known && (instr != NOP);
            if (instr_xfer) begin
                param_pos <= '0;
            end else if (in_xfer && (state == RECV_PARAMS)) begin
                param_pos <= param_pos + 1'b1;
            end
        end
    end

    // payload registers
    always_ff @(posedge clk) begin
        if (instr_xfer) begin
            opcode <= instr;
        end
        if (in_xfer && (state == RECV_PARAMS)) begin
            params[param_pos] <= in_data;
            if (last_param) begin
                data_addr <= params[0];
                end_addr  <= params[0] + in_data;
            end
        end
        // step one word per transfer
        if (mem_we || out_xfer) begin
            data_addr <= addr_next;
        end
    end

    // copy-in writes on the transfer edge
    assign mem_we    = (state == RECEIVE_DATA) && in_xfer;
    assign mem_waddr = to_index(data_addr);
    assign mem_wdata = in_data;

    // copy-out reads then waits in send_data
    assign mem_re    = (state == READ_MEM);
    assign mem_raddr = to_index(data_addr);
    // memory keeps its read register until the next read
    assign out_data  = mem_rdata;

    assign launch_valid   = (state == LAUNCH);
    assign launch_pc      = params[0];
    assign launch_timeout = params[LAST_PARAM];

endmodule

`default_nettype wire

/* design/kernel_launcher.sv */
`default_nettype none

`include "gpu_ctrl_defs.svh"

module kernel_launcher (
    input  logic                    clk,
    input  logic                    rst,
    // launch handshake from the host controller
    input  logic                    launch_valid,
    input  gpu_ctrl_pkg::gpu_addr_t launch_pc,
    input  gpu_ctrl_pkg::gpu_word_t launch_timeout,
    output logic                    launch_ready,
    // kernel port
    output logic                    kernel_start,
    output gpu_ctrl_pkg::gpu_addr_t kernel_pc,
    output logic                    kernel_abort,
    input  logic                    kernel_done,
    // status
    output logic                    kernel_busy,
    output logic                    kernel_timed_out
);
    import gpu_ctrl_pkg::*;

    localparam int PRESCALE_W = $clog2(`GPU_TIMEOUT_UNIT);
    localparam logic [PRESCALE_W-1:0] PRESCALE_LAST = PRESCALE_W'(`GPU_TIMEOUT_UNIT - 1);

    // timeout in units, zero means run forever
    gpu_word_t timeout_limit;
    // completed units of busy time
    gpu_word_t unit_count;
    // cycles within the current unit
    logic [PRESCALE_W-1:0] prescale;

    logic launch_xfer;
    logic unit_tick;
    logic timeout_hit;

    // one kernel at a time
    assign launch_ready = !kernel_busy;
    assign launch_xfer  = launch_valid && launch_ready;

    assign unit_tick = (prescale == PRESCALE_LAST);
    // this edge closes the last allowed unit
    assign timeout_hit = (timeout_limit != '0) && unit_tick &&
                         (unit_count == timeout_limit - 32'd1);

    // launch registers
    always_ff @(posedge clk) begin
        if (launch_xfer) begin
            kernel_pc     <= launch_pc;
            timeout_limit <= launch_timeout;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            kernel_busy      <= 1'b0;
            kernel_timed_out <= 1'b0;
            kernel_start     <= 1'b0;
            kernel_abort     <= 1'b0;
            prescale         <= '0;
            unit_count       <= '0;
        end else begin
            // pulses default low
            kernel_start <= 1'b0;
            kernel_abort <= 1'b0;
            if (launch_xfer) begin
                kernel_start     <= 1'b1;
                kernel_busy      <= 1'b1;
                kernel_timed_out <= 1'b0;
                prescale         <= '0;
                unit_count       <= '0;
            end else if (kernel_busy) begin
                // done wins over a timeout in the same cycle
                if (kernel_done) begin
                    kernel_busy <= 1'b0;
                end else if (timeout_hit) begin
                    kernel_abort     <= 1'b1;
                    kernel_busy      <= 1'b0;
                    kernel_timed_out <= 1'b1;
                end else if (unit_tick) begin
                    prescale   <= '0;
                    unit_count <= unit_count + 32'd1;
                end else begin
                    prescale <= prescale + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* design/gpu_ctrl_top.sv */
`default_nettype none

module gpu_ctrl_top (
    input  logic                      clk,
    input  logic                      rst,
    // host instruction channel
    input  logic                      instr_valid,
    input  gpu_ctrl_pkg::host_instr_e instr,
    output logic                      instr_ready,
    output logic                      instr_error,
    // host input channel
    input  logic                      in_valid,
    input  gpu_ctrl_pkg::gpu_word_t   in_data,
    output logic                      in_ready,
    // host output channel
    output logic                      out_valid,
    output gpu_ctrl_pkg::gpu_word_t   out_data,
    input  logic                      out_ready,
    // kernel side
    output logic                      kernel_start,
    output gpu_ctrl_pkg::gpu_addr_t   kernel_pc,
    output logic                      kernel_abort,
    input  logic                      kernel_done,
    output logic                      kernel_busy,
    output logic                      kernel_timed_out
);
    import gpu_ctrl_pkg::*;

    // controller to memory
    logic       mem_we;
    mem_index_t mem_waddr;
    gpu_word_t  mem_wdata;
    logic       mem_re;
    mem_index_t mem_raddr;
    gpu_word_t  mem_rdata;

    // controller to launcher
    logic      launch_valid;
    logic      launch_ready;
    gpu_addr_t launch_pc;
    gpu_word_t launch_timeout;

    host_controller u_host_controller (
        .clk            (clk),
        .rst            (rst),
        .instr_valid    (instr_valid),
        .instr          (instr),
        .instr_ready    (instr_ready),
        .instr_error    (instr_error),
        .in_valid       (in_valid),
        .in_data        (in_data),
        .in_ready       (in_ready),
        .out_valid      (out_valid),
        .out_data       (out_data),
        .out_ready      (out_ready),
        .mem_we         (mem_we),
        .mem_waddr      (mem_waddr),
        .mem_wdata      (mem_wdata),
        .mem_re         (mem_re),
        .mem_raddr      (mem_raddr),
        .mem_rdata      (mem_rdata),
        .launch_valid   (launch_valid),
        .launch_pc      (launch_pc),
        .launch_timeout (launch_timeout),
        .launch_ready   (launch_ready)
    );

    gpu_memory u_gpu_memory (
        .clk   (clk),
        .we    (mem_we),
        .waddr (mem_waddr),
        .wdata (mem_wdata),
        .re    (mem_re),
        .raddr (mem_raddr),
        .rdata (mem_rdata)
    );

    kernel_launcher u_kernel_launcher (
        .clk              (clk),
        .rst              (rst),
        .launch_valid     (launch_valid),
        .launch_pc        (launch_pc),
        .launch_timeout   (launch_timeout),
        .launch_ready     (launch_ready),
        .kernel_start     (kernel_start),
        .kernel_pc        (kernel_pc),
        .kernel_abort     (kernel_abort),
        .kernel_done      (kernel_done),
        .kernel_busy      (kernel_busy),
        .kernel_timed_out (kernel_timed_out)
    );

endmodule

`default_nettype wire

/* tb/gpu_ctrl_assertions.sv */
`default_nettype none

module gpu_ctrl_assertions (
    input logic                      clk,
    input logic                      rst,
    input logic                      instr_valid,
    input logic                      instr_ready,
    input gpu_ctrl_pkg::host_instr_e instr,
    input logic                      in_valid,
    input logic                      in_ready,
    input gpu_ctrl_pkg::gpu_word_t   in_data,
    input logic                      out_valid,
    input logic                      out_ready,
    input gpu_ctrl_pkg::gpu_word_t   out_data,
    input logic                      kernel_start,
    input logic                      kernel_abort,
    input logic                      kernel_busy
);
    import gpu_ctrl_pkg::*;

    // failed assertions so far
    int unsigned failures = 0;

    // a stalled valid keeps its payload until the transfer
    instr_hold: assert property (@(posedge clk) disable iff (!rst)
        instr_valid && !instr_ready |=> instr_valid && $stable(instr))
        else begin
            $error("instr dropped or changed while stalled");
            failures++;
        end

    in_hold: assert property (@(posedge clk) disable iff (!rst)
        in_valid && !in_ready |=> in_valid && $stable(in_data))
        else begin
            $error("in_data dropped or changed while stalled");
            failures++;
        end

    out_hold: assert property (@(posedge clk) disable iff (!rst)
        out_valid && !out_ready |=> out_valid && $stable(out_data))
        else begin
            $error("out_data dropped or changed while stalled");
            failures++;
        end

    // kernel pulses last one cycle
    start_pulse: assert property (@(posedge clk) disable iff (!rst)
        kernel_start |=> !kernel_start)
        else begin
            $error("kernel_start high for two cycles");
            failures++;
        end

    abort_pulse: assert property (@(posedge clk) disable iff (!rst)
        kernel_abort |=> !kernel_abort)
        else begin
            $error("kernel_abort high for two cycles");
            failures++;
        end

    // one kernel at a time
    start_when_idle: assert property (@(posedge clk) disable iff (!rst)
        kernel_start |-> !$past(kernel_busy))
        else begin
            $error("kernel_start while a kernel was busy");
            failures++;
        end

endmodule

`default_nettype wire

/* tb/gpu_ctrl_tb.sv */
`default_nettype none

`include "gpu_ctrl_defs.svh"

module gpu_ctrl_tb;
    import gpu_ctrl_pkg::*;

    logic        clk = 1'b0;
    logic        rst;
    logic        instr_valid;
    host_instr_e instr;
    logic        instr_ready;
    logic        instr_error;
    logic        in_valid;
    gpu_word_t   in_data;
    logic        in_ready;
    logic        out_valid;
    gpu_word_t   out_data;
    logic        out_ready;
    logic        kernel_start;
    gpu_addr_t   kernel_pc;
    logic        kernel_abort;
    logic        kernel_done;
    logic        kernel_busy;
    logic        kernel_timed_out;

    integer seed = 32'hcc57_f950;

    // records from the test data in file order
    string     cmd_q [$];
    gpu_word_t field_q [$];
    // done delay per pending launch
    // zero means the kernel never finishes
    gpu_word_t delay_q [$];
    gpu_word_t done_wait = '0;
    // expected memory contents built from copy-in records only
    gpu_word_t shadow [`GPU_MEM_WORDS];
    int        limit_cycles = 0;

    gpu_ctrl_top u_gpu_ctrl_top (.*);

    bind gpu_ctrl_top gpu_ctrl_assertions u_gpu_ctrl_assertions (.*);

    always #4 clk = ~clk;

    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("TESTS FAILED");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_word(input string name, input gpu_word_t expected,
                              input gpu_word_t actual);
        if (actual !== expected) begin
            stop_on_error($sformatf("CHECK FAILED at %0t: %s expected %h, actual %h",
                                    $time, name, expected, actual));
        end
    endtask

    task automatic check_addr(input string name, input gpu_addr_t expected,
                              input gpu_addr_t actual);
        if (actual !== expected) begin
            stop_on_error($sformatf("CHECK FAILED at %0t: %s expected %h, actual %h",
                                    $time, name, expected, actual));
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            stop_on_error($sformatf("CHECK FAILED at %0t: %s expected %b, actual %b",
                                    $time, name, expected, actual));
        end
    endtask

    task automatic take_field(input int fd, output gpu_word_t val);
        int code;
        code = $fscanf(fd, "%h", val);
        if (code != 1) begin
            stop_on_error("a test data record ends before all its fields");
        end else begin
            field_q.push_back(val);
        end
    endtask

    // loads every record and sizes the watchdog from them
    task automatic read_testdata();
        int        fd;
        int        code;
        int        i;
        int        words;
        int        timeouts;
        string     tok;
        string     rest;
        gpu_word_t v [5];
        words    = 0;
        timeouts = 0;
        fd = $fopen("tb/gpu_ctrl_testdata.txt", "r");
        if (fd == 0) begin
            stop_on_error("cannot open tb/gpu_ctrl_testdata.txt");
        end else begin
            code = $fscanf(fd, "%s", tok);
            while (code == 1) begin
                if (tok.substr(0, 0) == "#") begin
                    code = $fgets(rest, fd);
                end else begin
                    cmd_q.push_back(tok);
                    case (tok)
                        "W", "R": begin
                            take_field(fd, v[0]);
                            take_field(fd, v[1]);
                            for (i = 0; i < v[1] / 4; i++) begin
                                take_field(fd, v[2]);
                            end
                            words += 3 + v[1] / 4;
                        end
                        "L": begin
                            for (i = 0; i < 5; i++) begin
                                take_field(fd, v[i]);
                            end
                            words    += 3;
                            timeouts += v[1];
                        end
                        "E": begin
                            take_field(fd, v[0]);
                            take_field(fd, v[1]);
                            words += 2;
                        end
                        default: begin
                            stop_on_error({"unknown record letter in test data: ", tok});
                        end
                    endcase
                end
                code = $fscanf(fd, "%s", tok);
            end
            $fclose(fd);
        end
        limit_cycles = words * 20 + timeouts * `GPU_TIMEOUT_UNIT * 2 + 1000;
    endtask

    // all host tasks start and end on a falling edge
    task automatic send_instr(input gpu_word_t op);
        instr_valid = 1'b1;
        instr       = host_instr_e'(op);
        while (!instr_ready) begin
            @(negedge clk);
        end
        @(negedge clk);
        instr_valid = 1'b0;
        instr       = NOP;
    endtask

    task automatic send_input(input gpu_word_t word);
        int gap;
        gap = $unsigned($random(seed)) % 3;
        repeat (gap) @(negedge clk);
        in_valid = 1'b1;
        in_data  = word;
        while (!in_ready) begin
            @(negedge clk);
        end
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    task automatic copy_in(input gpu_addr_t addr, input gpu_addr_t count);
        int        i;
        gpu_addr_t word_pos;
        gpu_word_t word;
        send_instr(COPY_TO_GPU);
        send_input(addr);
        send_input(count);
        for (i = 0; i < count / 4; i++) begin
            word = field_q.pop_front();
            // byte address to word index wrapping at the memory depth
            word_pos = (addr >> 2) + i;
            shadow[word_pos % `GPU_MEM_WORDS] = word;
            send_input(word);
        end
        // nothing more may be taken after the last word
        check_flag("in_ready", 1'b0, in_ready);
    endtask

    task automatic copy_out(input gpu_addr_t addr, input gpu_addr_t count);
        int        got;
        gpu_addr_t word_pos;
        gpu_word_t expected;
        send_instr(COPY_FROM_GPU);
        send_input(addr);
        send_input(count);
        got = 0;
        while (got < count / 4) begin
            out_ready = ($random(seed) & 1) != 0;
            // a word seen here transfers on the next rising edge
            if (out_valid && out_ready) begin
                expected = field_q.pop_front();
                word_pos = (addr >> 2) + got;
                check_word("shadow memory", expected, shadow[word_pos % `GPU_MEM_WORDS]);
                check_word("out_data", expected, out_data);
                got++;
            end
            @(negedge clk);
        end
        out_ready = 1'b0;
        check_flag("out_valid", 1'b0, out_valid);
    endtask

    task automatic launch_kernel(input gpu_addr_t pc, input gpu_word_t timeout,
                                 input gpu_word_t delay, input logic expect_to,
                                 input logic wait_end);
        logic      prev_busy;
        logic      started;
        gpu_word_t aborts;
        gpu_word_t cycles;
        delay_q.push_back(delay);
        send_instr(KERNEL_LAUNCH);
        send_input(pc);
        send_input(timeout);
        aborts    = '0;
        started   = 1'b0;
        prev_busy = kernel_busy;
        // an earlier kernel may still be running here
        while (!started) begin
            @(negedge clk);
            if (kernel_abort) begin
                aborts++;
            end
            if (kernel_start) begin
                check_flag("kernel_busy before kernel_start", 1'b0, prev_busy);
                started = 1'b1;
            end
            prev_busy = kernel_busy;
        end
        check_addr("kernel_pc", pc, kernel_pc);
        check_flag("kernel_busy", 1'b1, kernel_busy);
        check_flag("kernel_timed_out", 1'b0, kernel_timed_out);
        if (wait_end) begin
            cycles = '0;
            while (kernel_busy) begin
                @(negedge clk);
                cycles++;
                if (kernel_abort) begin
                    aborts++;
                end
                check_flag("kernel_start", 1'b0, kernel_start);
            end
            // busy drops one cycle after done or after the full timeout
            check_word("kernel run cycles",
                       expect_to ? timeout * `GPU_TIMEOUT_UNIT : delay + 1, cycles);
            check_word("kernel_abort pulses", {31'd0, expect_to}, aborts);
            check_flag("kernel_timed_out", expect_to, kernel_timed_out);
        end
    endtask

    task automatic send_bare_opcode(input gpu_word_t op, input logic expect_err);
        int i;
        send_instr(op);
        check_flag("instr_error", expect_err, instr_error);
        for (i = 0; i < 2; i++) begin
            @(negedge clk);
            check_flag("instr_error", 1'b0, instr_error);
            check_flag("in_ready", 1'b0, in_ready);
        end
        check_flag("instr_ready", 1'b1, instr_ready);
    endtask

    task automatic run_record(input string cmd);
        gpu_word_t f [5];
        int        i;
        case (cmd)
            "W", "R": begin
                f[0] = field_q.pop_front();
                f[1] = field_q.pop_front();
                if (cmd == "W") begin
                    copy_in(f[0], f[1]);
                end else begin
                    copy_out(f[0], f[1]);
                end
            end
            "L": begin
                for (i = 0; i < 5; i++) begin
                    f[i] = field_q.pop_front();
                end
                launch_kernel(f[0], f[1], f[2], f[3][0], f[4][0]);
            end
            "E": begin
                f[0] = field_q.pop_front();
                f[1] = field_q.pop_front();
                send_bare_opcode(f[0], f[1][0]);
            end
        endcase
    endtask

    // kernel core model
    // raises done a set number of cycles after start
    always @(negedge clk) begin
        kernel_done = 1'b0;
        if (kernel_start) begin
            if (delay_q.size() == 0) begin
                stop_on_error("kernel_start pulsed with no launch pending");
            end else begin
                done_wait = delay_q.pop_front();
            end
        end else if (kernel_abort) begin
            done_wait = '0;
        end else if (done_wait != '0) begin
            done_wait = done_wait - 1;
            if (done_wait == '0) begin
                kernel_done = 1'b1;
            end
        end
    end

    // a failed bound assertion ends the run at once
    always @(negedge clk) begin
        if (u_gpu_ctrl_top.u_gpu_ctrl_assertions.failures != 0) begin
            stop_on_error("a concurrent assertion in the bound checker failed");
        end
    end

    // watchdog with its limit sized from the records
    initial begin
        wait (limit_cycles != 0);
        repeat (limit_cycles) @(posedge clk);
        stop_on_error($sformatf("run did not finish within %0d cycles", limit_cycles));
    end

    initial begin
        rst         = 1'b0;
        instr_valid = 1'b0;
        instr       = NOP;
        in_valid    = 1'b0;
        in_data     = '0;
        out_ready   = 1'b0;
        kernel_done = 1'b0;
        read_testdata();
        repeat (2) @(negedge clk);
        rst = 1'b1;
        @(negedge clk);
        while (cmd_q.size() != 0) begin
            run_record(cmd_q.pop_front());
        end
        if (u_gpu_ctrl_top.u_gpu_ctrl_assertions.failures != 0) begin
            stop_on_error("a concurrent assertion in the bound checker failed");
        end else begin
            $display("TESTS PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* tb/gpu_ctrl_testdata.txt */
# W addr count data...   R addr count expected...   counts in bytes, all fields hex
# L pc timeout done_delay timed_out wait_end          E opcode error_expected
# copy in then copy out of the same range
W 00000010 00000010 11111111 22222222 33333333 44444444
R 00000010 00000010 11111111 22222222 33333333 44444444
W 00000100 00000020 01234567 89abcdef deadbeef cafef00d 0badc0de 5a5a5a5a a5a5a5a5 00000000
R 00000100 00000020 01234567 89abcdef deadbeef cafef00d 0badc0de 5a5a5a5a a5a5a5a5 00000000
# overlapping copies, the last write wins
W 00000040 00000010 a0a0a0a0 b1b1b1b1 c2c2c2c2 d3d3d3d3
W 00000048 00000008 e4e4e4e4 f5f5f5f5
R 00000040 00000010 a0a0a0a0 b1b1b1b1 e4e4e4e4 f5f5f5f5
R 00000044 00000008 b1b1b1b1 e4e4e4e4
# empty copies take no data words
W 00000080 00000000
R 00000080 00000000
R 00000014 00000004 22222222
# low address bits dropped, index wraps at the top of memory
W 00000203 00000008 77777777 88888888
R 00000200 00000008 77777777 88888888
W 000003f8 00000010 10101010 20202020 30303030 40404040
R 000003f8 00000010 10101010 20202020 30303030 40404040
R 00000000 00000008 30303030 40404040
# bad opcode and nop, then normal traffic
E 00000007 1
E 00000000 0
R 00000010 00000008 11111111 22222222
# kernel that finishes on its own
L 00001000 00000000 0000000c 0 1
# one unit timeout with no done, then a clean run clears the flag
L 00002000 00000001 00000000 1 1
L 00003000 00000005 00000008 0 1
# second launch held off while the first one runs
L 00004000 00000000 00000030 0 0
L 00005000 00000000 00000004 0 1
E 00000005 1
W 00000010 00000004 99999999
R 00000010 00000008 99999999 22222222

/* flist.f */
+incdir+design
design/gpu_ctrl_pkg.sv
design/gpu_memory.sv
design/host_controller.sv
design/kernel_launcher.sv
design/gpu_ctrl_top.sv
tb/gpu_ctrl_assertions.sv
tb/gpu_ctrl_tb.sv

/* Bender.yml */
package:
  name: gpu_ctrl

sources:
  - include_dirs:
      - design
    files:
      - design/gpu_ctrl_pkg.sv
      - design/gpu_memory.sv
      - design/host_controller.sv
      - design/kernel_launcher.sv
      - design/gpu_ctrl_top.sv

  - target: simulation
    include_dirs:
      - design
    files:
      - tb/gpu_ctrl_assertions.sv
      - tb/gpu_ctrl_tb.sv
